// File: logic/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// cache geometry, one word per line
`define LSU_IDX_W 6
`define LSU_TAG_W (32 - `LSU_IDX_W - 2)

// cacheable window, upper bound exclusive
`define LSU_CACHE_BASE 32'h8000_0000
`define LSU_CACHE_LIMIT 32'h8040_0000

// cycles to wait for ack before giving up
`define LSU_BUS_TIMEOUT 16

`endif

// File: logic/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_SB,
    OP_SH,
    OP_SW
  } mem_op_e;

  // cache view of an address
  typedef struct packed {
    logic [`LSU_TAG_W-1:0] tag;
    logic [`LSU_IDX_W-1:0] idx;
    logic [1:0]            off;
  } lsu_addr_fields_t;

  typedef union packed {
    logic [31:0]      raw;
    lsu_addr_fields_t f;
  } lsu_addr_u;

  typedef struct packed {
    logic        valid;
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } lsu_rsp_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

// File: logic/bus_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_consts.svh"

module bus_timer (
  input  logic clk,
  input  logic rst_n_i,
  input  logic run_i,
  output logic expired_o
);

  localparam int CNT_W = $clog2(`LSU_BUS_TIMEOUT);

  logic [CNT_W-1:0] cnt_q;

  // the last counted cycle of the open bus cycle
  assign expired_o = run_i && (cnt_q == CNT_W'(`LSU_BUS_TIMEOUT - 1));

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
    end
    else if (!run_i)
    begin
      cnt_q <= '0;
    end
    else if (!expired_o)
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/l1d_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_consts.svh"

module l1d_cache (
  input  logic               clk,
  input  logic               rst_n_i,
  input  lsu_pkg::lsu_addr_u addr_i,
  input  logic               fill_i,
  input  logic [31:0]        fill_data_i,
  input  logic               inval_i,
  output logic               hit_o,
  output logic [31:0]        data_o
);

  localparam int LINES = 1 << `LSU_IDX_W;

  logic [31:0]           data_q [LINES];
  logic [`LSU_TAG_W-1:0] tag_q [LINES];
  logic [LINES-1:0]      valid_q;
  logic                  tag_match;

  assign tag_match = (tag_q[addr_i.f.idx] == addr_i.f.tag);
  assign hit_o     = valid_q[addr_i.f.idx] && tag_match;
  assign data_o    = data_q[addr_i.f.idx];

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= '0;
    end
    else if (fill_i)
    begin
      valid_q[addr_i.f.idx] <= 1'b1;
    end
    else if (inval_i && tag_match)
    begin
      // only the line that holds this address
      valid_q[addr_i.f.idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      data_q[addr_i.f.idx] <= fill_data_i;
      tag_q[addr_i.f.idx]  <= addr_i.f.tag;
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_datapath (
  input  lsu_pkg::mem_op_e   op_i,
  input  lsu_pkg::lsu_addr_u addr_i,
  input  logic [31:0]        wdata_i,
  input  logic [31:0]        word_i,
  output logic [3:0]         sel_o,
  output logic [31:0]        store_data_o,
  output logic [31:0]        load_data_o,
  output logic               misaligned_o
);

  logic [3:0]  sel_base;
  logic [31:0] shifted;
  logic        is_half;
  logic        is_word;

  assign is_half = op_i inside {lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH};
  assign is_word = op_i inside {lsu_pkg::OP_LW, lsu_pkg::OP_SW};

  assign misaligned_o = (is_half && addr_i.f.off[0]) || (is_word && (addr_i.f.off != 2'b00));

  // lanes start at the byte offset
  assign sel_base     = is_word ? 4'b1111 : (is_half ? 4'b0011 : 4'b0001);
  assign sel_o        = sel_base << addr_i.f.off;
  assign store_data_o = wdata_i << {addr_i.f.off, 3'b000};

  assign shifted = word_i >> {addr_i.f.off, 3'b000};

  always_comb
  begin
    case (op_i)
      lsu_pkg::OP_LB:  load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::OP_LBU: load_data_o = {24'h000000, shifted[7:0]};
      lsu_pkg::OP_LH:  load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::OP_LHU: load_data_o = {16'h0000, shifted[15:0]};
      default:         load_data_o = shifted;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/lsu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_ctrl (
  input  logic                clk,
  input  logic                rst_n_i,
  input  lsu_pkg::lsu_req_t   req_i,
  input  logic                hit_i,
  input  logic                misaligned_i,
  input  logic                expired_i,
  input  lsu_pkg::wb_s2m_t    wb_i,
  input  logic [31:0]         load_data_i,
  input  logic [3:0]          sel_i,
  input  logic [31:0]         store_data_i,
  output logic                ready_o,
  output lsu_pkg::lsu_rsp_t   rsp_o,
  output lsu_pkg::mem_op_e    cur_op_o,
  output lsu_pkg::lsu_addr_u  cur_addr_o,
  output logic                fill_o,
  output logic                inval_o,
  output lsu_pkg::wb_m2s_t    wb_o
);

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_BUS, S_RESP} state_e;

  state_e             state_q;
  state_e             state_d;
  lsu_pkg::mem_op_e   op_q;
  lsu_pkg::lsu_addr_u addr_q;
  logic               cyc_q;
  logic               we_q;
  logic [31:0]        adr_q;
  logic [31:0]        dat_q;
  logic [3:0]         sel_q;
  logic               err_q;
  logic [31:0]        rdata_q;
  logic               accept;
  logic               is_load;
  logic               is_store;
  logic               cacheable;
  logic               bad_op;
  logic               hit_ok;
  logic               start_bus;
  logic               bus_done;

  assign ready_o  = (state_q == S_IDLE);
  assign accept   = req_i.valid && ready_o;
  assign is_load  = op_q inside {lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_LH,
                                 lsu_pkg::OP_LHU, lsu_pkg::OP_LW};
  assign is_store = op_q inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
  assign cacheable = (addr_q.raw >= `LSU_CACHE_BASE) && (addr_q.raw < `LSU_CACHE_LIMIT);

  assign bad_op    = misaligned_i || !(is_load || is_store);
  assign hit_ok    = is_load && cacheable && hit_i;
  assign start_bus = (state_q == S_LOOKUP) && !bad_op && !hit_ok;
  // ack wins over a timeout in the same cycle
  assign bus_done  = (state_q == S_BUS) && (wb_i.ack || expired_i);

  assign fill_o  = (state_q == S_BUS) && wb_i.ack && is_load && cacheable;
  assign inval_o = start_bus && is_store;

  assign cur_op_o   = op_q;
  assign cur_addr_o = addr_q;

  always_comb
  begin
    wb_o.cyc = cyc_q;
    wb_o.stb = cyc_q;
    wb_o.we  = we_q;
    wb_o.adr = adr_q;
    wb_o.dat = dat_q;
    wb_o.sel = sel_q;
  end

  always_comb
  begin
    rsp_o = '0;
    if (state_q == S_LOOKUP && bad_op)
    begin
      rsp_o.valid = 1'b1;
      rsp_o.err   = 1'b1;
    end
    else if (state_q == S_LOOKUP && hit_ok)
    begin
      rsp_o.valid = 1'b1;
      rsp_o.rdata = load_data_i;
    end
    else if (state_q == S_RESP)
    begin
      rsp_o.valid = 1'b1;
      rsp_o.err   = err_q;
      rsp_o.rdata = rdata_q;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (accept) state_d = S_LOOKUP;
      S_LOOKUP: state_d = start_bus ? S_BUS : S_IDLE;
      S_BUS:    if (bus_done) state_d = S_RESP;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= S_IDLE;
      op_q    <= lsu_pkg::OP_NONE;
      cyc_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        op_q <= req_i.op;
      end
      if (start_bus)
      begin
        cyc_q <= 1'b1;
      end
      else if (bus_done)
      begin
        cyc_q <= 1'b0;
      end
    end
  end

  // dat holds the raw store word until the lanes are formed
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q.raw <= req_i.addr;
      dat_q      <= req_i.wdata;
    end
    if (start_bus)
    begin
      we_q  <= is_store;
      adr_q <= {addr_q.raw[31:2], 2'b00};
      sel_q <= is_store ? sel_i : 4'hf;
      dat_q <= store_data_i;
    end
    if (bus_done)
    begin
      err_q   <= !wb_i.ack;
      rdata_q <= wb_i.ack ? load_data_i : 32'h0;
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              ready_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output lsu_pkg::wb_m2s_t  wb_o,
  input  lsu_pkg::wb_s2m_t  wb_i
);

  lsu_pkg::mem_op_e   cur_op;
  lsu_pkg::lsu_addr_u cur_addr;
  logic               hit;
  logic               misaligned;
  logic               expired;
  logic               fill;
  logic               inval;
  logic [3:0]         sel;
  logic [31:0]        store_data;
  logic [31:0]        load_data;
  logic [31:0]        cache_word;
  logic [31:0]        load_word;

  // bus word in the ack cycle, cached word otherwise
  assign load_word = wb_i.ack ? wb_i.dat : cache_word;

  lsu_ctrl ctrl_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .hit_i        (hit),
    .misaligned_i (misaligned),
    .expired_i    (expired),
    .wb_i         (wb_i),
    .load_data_i  (load_data),
    .sel_i        (sel),
    .store_data_i (store_data),
    .ready_o      (ready_o),
    .rsp_o        (rsp_o),
    .cur_op_o     (cur_op),
    .cur_addr_o   (cur_addr),
    .fill_o       (fill),
    .inval_o      (inval),
    .wb_o         (wb_o)
  );

  bus_timer timer_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .run_i     (wb_o.cyc),
    .expired_o (expired)
  );

  l1d_cache cache_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .addr_i      (cur_addr),
    .fill_i      (fill),
    .fill_data_i (wb_i.dat),
    .inval_i     (inval),
    .hit_o       (hit),
    .data_o      (cache_word)
  );

  // store data comes back from the registered wishbone data word
  lsu_datapath datapath_i (
    .op_i         (cur_op),
    .addr_i       (cur_addr),
    .wdata_i      (wb_o.dat),
    .word_i       (load_word),
    .sel_o        (sel),
    .store_data_o (store_data),
    .load_data_o  (load_data),
    .misaligned_o (misaligned)
  );

endmodule

`default_nettype wire

// File: verification/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model (
  input  logic             clk,
  input  logic             rst_n_i,
  input  lsu_pkg::wb_m2s_t wb_i,
  output lsu_pkg::wb_s2m_t wb_o
);

  localparam logic [31:0] INIT_OFFSET = 32'h9a3c_e5f1;

  logic [31:0] mem [logic [29:0]];
  int          seed = 32'h840c0a92;
  int          cycle_count;
  logic        started_q;
  logic [1:0]  wait_q;
  logic        ack_q;
  logic [31:0] dat_q;
  logic        in_hole;

  // never acknowledged
  assign in_hole = (wb_i.adr[31:12] == 20'h90000);
  assign wb_o    = {ack_q, dat_q};

  function automatic logic [31:0] read_word(input logic [29:0] widx);
    if (mem.exists(widx))
    begin
      return mem[widx];
    end
    return {widx, 2'b00} * 3 + INIT_OFFSET;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  sel);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i])
      begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  always @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q       <= 1'b0;
      started_q   <= 1'b0;
      wait_q      <= 2'd0;
      dat_q       <= 32'h0;
      cycle_count <= 0;
    end
    else if (!(wb_i.cyc && wb_i.stb) || ack_q)
    begin
      ack_q     <= 1'b0;
      started_q <= 1'b0;
    end
    else if (!started_q)
    begin
      // new cycle, pick 0 to 3 wait states
      started_q   <= 1'b1;
      cycle_count <= cycle_count + 1;
      wait_q      <= 2'($random(seed));
    end
    else if (wait_q != 2'd0)
    begin
      wait_q <= wait_q - 2'd1;
    end
    else if (!in_hole)
    begin
      ack_q <= 1'b1;
      if (wb_i.we)
      begin
        mem[wb_i.adr[31:2]] = merge_bytes(read_word(wb_i.adr[31:2]), wb_i.dat, wb_i.sel);
        dat_q <= 32'h0;
      end
      else
      begin
        dat_q <= read_word(wb_i.adr[31:2]);
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/lsu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_properties (
  input logic              clk,
  input logic              rst_n_i,
  input logic              ready_i,
  input lsu_pkg::lsu_rsp_t rsp_i,
  input lsu_pkg::wb_m2s_t  wb_m2s_i,
  input lsu_pkg::wb_s2m_t  wb_s2m_i
);

  int fail_count = 0;

  // request held until the slave answers
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_m2s_i.stb && !wb_s2m_i.ack) |=>
      ($stable(wb_m2s_i.adr) && $stable(wb_m2s_i.sel) && $stable(wb_m2s_i.we)))
  else
  begin
    fail_count++;
    $error("wishbone request changed while waiting for ack");
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_i.valid |=> !rsp_i.valid)
  else
  begin
    fail_count++;
    $error("response valid held longer than one cycle");
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_m2s_i.cyc |-> !ready_i)
  else
  begin
    fail_count++;
    $error("ready high during an open bus cycle");
  end

endmodule

bind lsu_top lsu_properties props_i (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .ready_i  (ready_o),
  .rsp_i    (rsp_o),
  .wb_m2s_i (wb_o),
  .wb_s2m_i (wb_i)
);

`default_nettype wire

// File: verification/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;

  localparam int          MAX_CASES   = 32;
  localparam int          FIELDS      = 6;
  localparam int          WAIT_LIMIT  = 64;
  localparam logic [31:0] INIT_OFFSET = 32'h9a3c_e5f1;

  logic              clk;
  logic              rst_n;
  lsu_pkg::lsu_req_t req;
  logic              ready;
  lsu_pkg::lsu_rsp_t rsp;
  lsu_pkg::wb_m2s_t  wb_m2s;
  lsu_pkg::wb_s2m_t  wb_s2m;
  logic [31:0]       case_mem [FIELDS*MAX_CASES];
  logic [31:0]       mirror [logic [29:0]];

  lsu_top dut_i (
    .clk     (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .ready_o (ready),
    .rsp_o   (rsp),
    .wb_o    (wb_m2s),
    .wb_i    (wb_s2m)
  );

  wb_mem_model mem_i (
    .clk     (clk),
    .rst_n_i (rst_n),
    .wb_i    (wb_m2s),
    .wb_o    (wb_s2m)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      stop_with_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // outputs settled, inputs may change
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] mirror_word(input logic [31:0] addr);
    if (mirror.exists(addr[31:2]))
    begin
      return mirror[addr[31:2]];
    end
    return {addr[31:2], 2'b00} * 3 + INIT_OFFSET;
  endfunction

  function automatic logic [31:0] expected_load(input lsu_pkg::mem_op_e op,
                                                input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = mirror_word(addr);
    b    = word[{addr[1:0], 3'b000} +: 8];
    h    = word[{addr[1], 4'b0000} +: 16];
    case (op)
      lsu_pkg::OP_LB:  return {{24{b[7]}}, b};
      lsu_pkg::OP_LBU: return {24'h000000, b};
      lsu_pkg::OP_LH:  return {{16{h[15]}}, h};
      lsu_pkg::OP_LHU: return {16'h0000, h};
      default:         return word;
    endcase
  endfunction

  task automatic apply_store(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
    logic [31:0] word;
    int          nbytes;
    int          off;
    word   = mirror_word(addr);
    nbytes = (op == lsu_pkg::OP_SB) ? 1 : ((op == lsu_pkg::OP_SH) ? 2 : 4);
    off    = int'(addr[1:0]);
    for (int i = 0; i < nbytes; i++)
    begin
      word[8*(off+i) +: 8] = wdata[8*i +: 8];
    end
    mirror[addr[31:2]] = word;
  endtask

  task automatic run_case(input int n);
    lsu_pkg::mem_op_e op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      exp_rdata;
    logic             exp_err;
    logic             exp_bus;
    logic             is_load;
    int               waited;
    int               latency;
    int               cycles_before;
    op        = lsu_pkg::mem_op_e'(case_mem[FIELDS*n][3:0]);
    addr      = case_mem[FIELDS*n+1];
    wdata     = case_mem[FIELDS*n+2];
    exp_rdata = case_mem[FIELDS*n+3];
    exp_err   = case_mem[FIELDS*n+4][0];
    exp_bus   = case_mem[FIELDS*n+5][0];
    is_load   = op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_LH,
                           lsu_pkg::OP_LHU, lsu_pkg::OP_LW};
    waited = 0;
    while (!ready)
    begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        stop_with_failure($sformatf("ready_o never came back before case %0d", n));
      end
    end
    req.valid     = 1'b1;
    req.op        = op;
    req.addr      = addr;
    req.wdata     = wdata;
    cycles_before = mem_i.cycle_count;
    next_cycle();
    req = '0;
    latency = 1;
    while (!rsp.valid)
    begin
      next_cycle();
      latency++;
      if (latency > WAIT_LIMIT)
      begin
        stop_with_failure($sformatf("no response for case %0d", n));
      end
    end
    check_value("rsp_o.err", 32'(rsp.err), 32'(exp_err));
    check_value("rsp_o.rdata", rsp.rdata, exp_rdata);
    check_value("bus cycle seen", 32'(mem_i.cycle_count != cycles_before), 32'(exp_bus));
    check_value("wb_o.cyc", 32'(wb_m2s.cyc), 32'h0);
    if (!exp_bus)
    begin
      check_value("response latency", 32'(latency), 32'd1);
    end
    else if (exp_err)
    begin
      // cyc opens after the lookup cycle, then the timer runs out
      check_value("timeout latency", 32'(latency), 32'(`LSU_BUS_TIMEOUT + 2));
    end
    if (is_load && !exp_err)
    begin
      check_value("rsp_o.rdata from mirror", rsp.rdata, expected_load(op, addr));
    end
    else if (!is_load && !exp_err)
    begin
      apply_store(op, addr, wdata);
    end
  endtask

  initial
  begin
    int n;
    req   = '0;
    rst_n = 1'b0;
    for (int i = 0; i < FIELDS*MAX_CASES; i++)
    begin
      case_mem[i] = 32'h0;
    end
    $readmemh("verification/lsu_cases.txt", case_mem);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    check_value("ready_o", 32'(ready), 32'h1);
    check_value("rsp_o.valid", 32'(rsp.valid), 32'h0);
    check_value("wb_o.cyc", 32'(wb_m2s.cyc), 32'h0);
    check_value("wb_o.stb", 32'(wb_m2s.stb), 32'h0);
    n = 0;
    while (n < MAX_CASES && case_mem[FIELDS*n] != 32'h0)
    begin
      run_case(n);
      n++;
    end
    if (n == 0)
    begin
      stop_with_failure("no cases were read from the case file");
    end
    if (dut_i.props_i.fail_count != 0)
    begin
      stop_with_failure("assertion failures were reported");
    end
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/lsu_cases.txt
// columns: op addr wdata exp_rdata exp_err exp_bus
// op 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 sb, 7 sh, 8 sw, 0 ends the list
1 00001000 00000000 fffffff1 0 1
1 00001001 00000000 00000015 0 1
1 00001002 00000000 0000003d 0 1
1 00001003 00000000 ffffff9a 0 1
2 00001000 00000000 000000f1 0 1
2 00001001 00000000 00000015 0 1
2 00001002 00000000 0000003d 0 1
2 00001003 00000000 0000009a 0 1
3 00001000 00000000 000015f1 0 1
3 00001002 00000000 ffff9a3d 0 1
4 00001000 00000000 000015f1 0 1
4 00001002 00000000 00009a3d 0 1
5 00001000 00000000 9a3d15f1 0 1
5 80000100 00000000 1a3ce8f1 0 1
5 80000100 00000000 1a3ce8f1 0 0
1 80000103 00000000 0000001a 0 0
3 80000100 00000000 ffffe8f1 0 0
6 80000101 000000c7 00000000 0 1
5 80000100 00000000 1a3cc7f1 0 1
7 80000102 00004b2e 00000000 0 1
5 80000100 00000000 4b2ec7f1 0 1
8 80000100 0f1e2d3c 00000000 0 1
4 80000102 00000000 00000f1e 0 1
2 80000100 00000000 0000003c 0 0
3 00001001 00000000 00000000 1 0
8 80000102 12345678 00000000 1 0
5 90000000 00000000 00000000 1 1
0 00000000 00000000 00000000 0 0

// File: files.f
+incdir+logic
logic/lsu_pkg.sv
logic/bus_timer.sv
logic/l1d_cache.sv
logic/lsu_datapath.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
verification/wb_mem_model.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
